// File: hdl/racing_pkg.sv
`default_nettype none

package racing_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [7:0] bus_addr_t;
  typedef logic [8:0] coord_t;
  typedef logic [5:0] ram_index_t;

  // beam timing, pixels across and lines down
  localparam coord_t H_DISPLAY    = 9'd256;
  localparam coord_t H_TOTAL      = 9'd309;
  localparam coord_t H_SYNC_START = 9'd279;
  localparam coord_t H_SYNC_END   = 9'd301;
  localparam coord_t V_DISPLAY    = 9'd240;
  localparam coord_t V_TOTAL      = 9'd262;
  localparam coord_t V_SYNC_START = 9'd245;
  localparam coord_t V_SYNC_END   = 9'd247;

  // work RAM occupies everything below the input registers
  localparam int        RAM_DEPTH = 64;
  localparam bus_addr_t RAM_TOP   = 8'h40;

  localparam ram_index_t SLOT_PLAYER_X  = 6'd2;
  localparam ram_index_t SLOT_PLAYER_Y  = 6'd3;
  localparam ram_index_t SLOT_ENEMY_X   = 6'd4;
  localparam ram_index_t SLOT_ENEMY_Y   = 6'd5;
  localparam ram_index_t SLOT_TRACK_POS = 6'd8;

  localparam bus_addr_t IN_HPOS  = 8'h40;
  localparam bus_addr_t IN_VPOS  = 8'h41;
  localparam bus_addr_t IN_FLAGS = 8'h42;

  localparam int FLAG_DISPLAY = 0;
  localparam int FLAG_HPADDLE = 1;
  localparam int FLAG_VPADDLE = 2;
  localparam int FLAG_HSYNC   = 3;
  localparam int FLAG_VSYNC   = 4;
  localparam int FLAG_COLLIDE = 5;

  // row fetch columns, staggered so the two renderers never load together
  localparam coord_t LOAD_PLAYER = 9'd256;
  localparam coord_t LOAD_ENEMY  = 9'd260;

  typedef struct packed {
    coord_t hpos;
    coord_t vpos;
    logic   display_on;
  } beam_t;

  typedef struct packed {
    byte_t player_x;
    byte_t player_y;
    byte_t enemy_x;
    byte_t enemy_y;
    byte_t track_pos;
  } scene_t;

  typedef struct packed {
    logic       hsync;
    logic       vsync;
    logic [3:0] rgb;
  } video_t;

  typedef enum logic [2:0] {
    WAIT_VSTART,
    WAIT_LOAD,
    FETCH,
    WAIT_HSTART,
    DRAW
  } sprite_state_t;

endpackage

`default_nettype wire

// File: hdl/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing (
  input  wire                clk,
  input  wire                arst_n,
  output racing_pkg::beam_t  beam,
  output logic               hsync,
  output logic               vsync
);

  racing_pkg::coord_t hpos;
  racing_pkg::coord_t vpos;
  logic               line_end;
  logic               frame_end;

  assign line_end  = (hpos == racing_pkg::H_TOTAL - 9'd1);
  assign frame_end = (vpos == racing_pkg::V_TOTAL - 9'd1);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hpos <= '0;
      vpos <= '0;
    end else if (line_end) begin
      hpos <= '0;
      if (frame_end) begin
        vpos <= '0;
      end else begin
        vpos <= vpos + 9'd1;
      end
    end else begin
      hpos <= hpos + 9'd1;
    end
  end

  // syncs come out one clock behind the beam
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hsync <= 1'b0;
      vsync <= 1'b0;
    end else begin
      hsync <= (hpos >= racing_pkg::H_SYNC_START) && (hpos <= racing_pkg::H_SYNC_END);
      vsync <= (vpos >= racing_pkg::V_SYNC_START) && (vpos <= racing_pkg::V_SYNC_END);
    end
  end

  assign beam.hpos = hpos;
  assign beam.vpos = vpos;
  assign beam.display_on = (hpos < racing_pkg::H_DISPLAY) && (vpos < racing_pkg::V_DISPLAY);

endmodule

`default_nettype wire

// File: hdl/game_memory.sv
`timescale 1ns/1ps
`default_nettype none

module game_memory (
  input  wire                    clk,
  input  wire                    arst_n,
  input  racing_pkg::bus_addr_t  address,
  input  racing_pkg::byte_t      wdata,
  input  wire                    write,
  output racing_pkg::byte_t      rdata,
  input  racing_pkg::beam_t      beam,
  input  wire                    hsync,
  input  wire                    vsync,
  input  wire                    hpaddle,
  input  wire                    vpaddle,
  input  wire                    collision,
  output racing_pkg::scene_t     scene
);

  racing_pkg::byte_t      ram [racing_pkg::RAM_DEPTH];
  racing_pkg::ram_index_t index;
  racing_pkg::byte_t      flags;
  logic                   in_ram;

  assign index  = address[5:0];
  assign in_ram = (address < racing_pkg::RAM_TOP);

  // cleared so both cars start parked at the origin
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < racing_pkg::RAM_DEPTH; i++) begin
        ram[i] <= '0;
      end
    end else if (write && in_ram) begin
      ram[index] <= wdata;
    end
  end

  always_comb begin
    flags = '0;
    flags[racing_pkg::FLAG_DISPLAY] = beam.display_on;
    flags[racing_pkg::FLAG_HPADDLE] = hpaddle;
    flags[racing_pkg::FLAG_VPADDLE] = vpaddle;
    flags[racing_pkg::FLAG_HSYNC]   = hsync;
    flags[racing_pkg::FLAG_VSYNC]   = vsync;
    flags[racing_pkg::FLAG_COLLIDE] = collision;
  end

  // anything unmapped reads as zero
  always_comb begin
    rdata = '0;
    if (in_ram) begin
      rdata = ram[index];
    end else begin
      case (address)
        racing_pkg::IN_HPOS:  rdata = beam.hpos[7:0];
        racing_pkg::IN_VPOS:  rdata = beam.vpos[7:0];
        racing_pkg::IN_FLAGS: rdata = flags;
        default:              rdata = '0;
      endcase
    end
  end

  assign scene.player_x  = ram[racing_pkg::SLOT_PLAYER_X];
  assign scene.player_y  = ram[racing_pkg::SLOT_PLAYER_Y];
  assign scene.enemy_x   = ram[racing_pkg::SLOT_ENEMY_X];
  assign scene.enemy_y   = ram[racing_pkg::SLOT_ENEMY_Y];
  assign scene.track_pos = ram[racing_pkg::SLOT_TRACK_POS];

endmodule

`default_nettype wire

// File: hdl/sprite_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_renderer #(
  parameter racing_pkg::coord_t load_hpos = racing_pkg::LOAD_PLAYER
) (
  input  wire                clk,
  input  wire                arst_n,
  input  racing_pkg::beam_t  beam,
  input  racing_pkg::byte_t  x,
  input  racing_pkg::byte_t  y,
  output logic               gfx
);

  racing_pkg::sprite_state_t state;
  logic [3:0]                ycount;
  logic [3:0]                xcount;
  logic [7:0]                outbits;
  logic [7:0]                row_bits;
  logic                      vstart;
  logic                      hstart;

  assign vstart = (beam.vpos == {1'b0, y});
  assign hstart = (beam.hpos == {1'b0, x});

  // car shape, eight bits across, each bit two pixels wide
  always_comb begin
    case (ycount)
      4'd0:    row_bits = 8'b00011000;
      4'd1:    row_bits = 8'b00111100;
      4'd2:    row_bits = 8'b11111111;
      4'd3:    row_bits = 8'b11111111;
      4'd4:    row_bits = 8'b00111100;
      4'd5:    row_bits = 8'b00100100;
      4'd6:    row_bits = 8'b00111100;
      4'd7:    row_bits = 8'b01111110;
      4'd8:    row_bits = 8'b01111110;
      4'd9:    row_bits = 8'b00111100;
      4'd10:   row_bits = 8'b00100100;
      4'd11:   row_bits = 8'b00111100;
      4'd12:   row_bits = 8'b11111111;
      4'd13:   row_bits = 8'b11111111;
      4'd14:   row_bits = 8'b01111110;
      default: row_bits = 8'b00111100;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= racing_pkg::WAIT_VSTART;
      ycount <= '0;
      xcount <= '0;
    end else begin
      case (state)
        racing_pkg::WAIT_VSTART: begin
          ycount <= '0;
          if (vstart) begin
            state <= racing_pkg::WAIT_LOAD;
          end
        end
        racing_pkg::WAIT_LOAD: begin
          if (beam.hpos == load_hpos) begin
            state <= racing_pkg::FETCH;
          end
        end
        racing_pkg::FETCH: begin
          state <= racing_pkg::WAIT_HSTART;
        end
        racing_pkg::WAIT_HSTART: begin
          xcount <= '0;
          if (hstart) begin
            state <= racing_pkg::DRAW;
          end
        end
        racing_pkg::DRAW: begin
          xcount <= xcount + 4'd1;
          if (xcount == 4'd15) begin
            ycount <= ycount + 4'd1;
            state  <= (ycount == 4'd15) ? racing_pkg::WAIT_VSTART : racing_pkg::WAIT_LOAD;
          end
        end
        default: state <= racing_pkg::WAIT_VSTART;
      endcase
    end
  end

  // row latch, loaded once per line
  always_ff @(posedge clk) begin
    if (state == racing_pkg::FETCH) begin
      outbits <= row_bits;
    end
  end

  assign gfx = (state == racing_pkg::DRAW) && outbits[3'd7 - xcount[3:1]];

endmodule

`default_nettype wire

// File: hdl/playfield.sv
`timescale 1ns/1ps
`default_nettype none

module playfield (
  input  wire                clk,
  input  wire                arst_n,
  input  racing_pkg::beam_t  beam,
  input  racing_pkg::byte_t  track_pos,
  input  wire                player_gfx,
  input  wire                enemy_gfx,
  output logic               collision,
  output logic [3:0]         rgb
);

  logic track_offside;
  logic track_shoulder;
  logic track_gfx;
  logic player_on;
  logic r;
  logic g;
  logic b;

  assign track_offside  = (beam.hpos[7:5] == 3'd0) || (beam.hpos[7:5] == 3'd7);
  assign track_shoulder = (beam.hpos[7:3] == 5'd3) || (beam.hpos[7:3] == 5'd28);
  // gap line scrolls with the low track position bits
  assign track_gfx = (beam.vpos[5:1] != track_pos[5:1]) && track_offside;

  assign player_on = beam.display_on && player_gfx;

  // level holds for the rest of the frame once any overlap is seen
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      collision <= 1'b0;
    end else if (player_on && (enemy_gfx || track_gfx)) begin
      collision <= 1'b1;
    end else if (beam.vpos == '0) begin
      collision <= 1'b0;
    end
  end

  assign r = beam.display_on && (player_gfx || enemy_gfx || track_shoulder);
  assign g = beam.display_on && (player_gfx || track_gfx);
  assign b = beam.display_on && (enemy_gfx || track_shoulder);

  assign rgb = {1'b0, b, g, r};

endmodule

`default_nettype wire

// File: hdl/racing_game_top.sv
`timescale 1ns/1ps
`default_nettype none

module racing_game_top (
  input  wire                    clk,
  input  wire                    arst_n,
  input  wire                    hpaddle,
  input  wire                    vpaddle,
  input  racing_pkg::bus_addr_t  address,
  input  racing_pkg::byte_t      wdata,
  input  wire                    write,
  output racing_pkg::byte_t      rdata,
  output racing_pkg::video_t     video
);

  racing_pkg::beam_t  beam;
  racing_pkg::scene_t scene;
  logic               hsync;
  logic               vsync;
  logic               player_gfx;
  logic               enemy_gfx;
  logic               collision;
  logic [3:0]         rgb;

  video_timing u_video_timing (
    .clk(clk), .arst_n(arst_n), .beam(beam), .hsync(hsync), .vsync(vsync)
  );

  game_memory u_game_memory (
    .clk(clk), .arst_n(arst_n), .address(address), .wdata(wdata), .write(write),
    .rdata(rdata), .beam(beam), .hsync(hsync), .vsync(vsync), .hpaddle(hpaddle),
    .vpaddle(vpaddle), .collision(collision), .scene(scene)
  );

  sprite_renderer #(.load_hpos(racing_pkg::LOAD_PLAYER)) u_player (
    .clk(clk), .arst_n(arst_n), .beam(beam),
    .x(scene.player_x), .y(scene.player_y), .gfx(player_gfx)
  );

  sprite_renderer #(.load_hpos(racing_pkg::LOAD_ENEMY)) u_enemy (
    .clk(clk), .arst_n(arst_n), .beam(beam),
    .x(scene.enemy_x), .y(scene.enemy_y), .gfx(enemy_gfx)
  );

  playfield u_playfield (
    .clk(clk), .arst_n(arst_n), .beam(beam), .track_pos(scene.track_pos),
    .player_gfx(player_gfx), .enemy_gfx(enemy_gfx), .collision(collision), .rgb(rgb)
  );

  assign video.hsync = hsync;
  assign video.vsync = vsync;
  assign video.rgb   = rgb;

endmodule

`default_nettype wire

// File: bench/racing_game_properties.sv
`timescale 1ns/1ps
`default_nettype none

module racing_game_properties (
  input  wire                    clk,
  input  wire                    arst_n,
  input  wire                    hpaddle,
  input  wire                    vpaddle,
  input  racing_pkg::bus_addr_t  address,
  input  racing_pkg::byte_t      wdata,
  input  wire                    write,
  input  racing_pkg::byte_t      rdata,
  input  racing_pkg::video_t     video,
  input  racing_pkg::beam_t      model_beam
);

  localparam logic [10:0] VSYNC_CYCLES =
    11'(racing_pkg::V_SYNC_END - racing_pkg::V_SYNC_START + 9'd1) * 11'(racing_pkg::H_TOTAL);

  logic              hsync_q;
  logic              vsync_q;
  logic              h_seen;
  logic              c3_seen;
  logic [9:0]        h_gap;
  logic [10:0]       v_len;
  logic [1:0]        settle;
  racing_pkg::byte_t px;
  racing_pkg::byte_t py;
  logic              h_rise;
  logic              v_fall;
  logic              frame_start;
  logic              pos_write;
  logic              in_box;
  logic              colour3;
  logic              flags_ok;

  assign h_rise      = video.hsync && !hsync_q;
  assign v_fall      = !video.vsync && vsync_q;
  assign frame_start = (model_beam.hpos == '0) && (model_beam.vpos == '0);
  assign colour3     = (video.rgb == 4'd3);
  assign pos_write   = write && ((address == {2'b00, racing_pkg::SLOT_PLAYER_X}) ||
                                 (address == {2'b00, racing_pkg::SLOT_PLAYER_Y}));
  assign in_box = (model_beam.hpos > {1'b0, px}) && (model_beam.hpos <= {1'b0, px} + 9'd16) &&
                  (model_beam.vpos > {1'b0, py}) && (model_beam.vpos <= {1'b0, py} + 9'd16);

  assign flags_ok = (rdata[racing_pkg::FLAG_DISPLAY] == model_beam.display_on) &&
                    (rdata[racing_pkg::FLAG_HPADDLE] == hpaddle) &&
                    (rdata[racing_pkg::FLAG_VPADDLE] == vpaddle) &&
                    (rdata[racing_pkg::FLAG_HSYNC] == video.hsync) &&
                    (rdata[racing_pkg::FLAG_VSYNC] == video.vsync) &&
                    (rdata[7:6] == 2'b00);

  // player position snooped from the bus, trusted two frames after its last write
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hsync_q <= 1'b0;
      vsync_q <= 1'b0;
      h_seen  <= 1'b0;
      h_gap   <= '0;
      v_len   <= '0;
      px      <= '0;
      py      <= '0;
      settle  <= '0;
      c3_seen <= 1'b0;
    end else begin
      hsync_q <= video.hsync;
      vsync_q <= video.vsync;
      h_gap   <= h_rise ? 10'd1 : h_gap + 10'd1;
      h_seen  <= h_seen || h_rise;
      v_len   <= video.vsync ? v_len + 11'd1 : 11'd0;
      if (write && (address == {2'b00, racing_pkg::SLOT_PLAYER_X})) begin
        px <= wdata;
      end
      if (write && (address == {2'b00, racing_pkg::SLOT_PLAYER_Y})) begin
        py <= wdata;
      end
      if (pos_write) begin
        settle <= '0;
      end else if (frame_start && (settle != 2'd3)) begin
        settle <= settle + 2'd1;
      end
      c3_seen <= frame_start ? colour3 : (c3_seen || colour3);
    end
  end

  a_flags: assert property (@(posedge clk) disable iff (!arst_n)
    (address == racing_pkg::IN_FLAGS) |-> flags_ok)
    else $error("flags byte disagrees with paddles, syncs or display enable");

  a_hsync_period: assert property (@(posedge clk) disable iff (!arst_n)
    (h_rise && h_seen) |-> (h_gap == {1'b0, racing_pkg::H_TOTAL}))
    else $error("hsync rise spacing is not one line");

  a_vsync_width: assert property (@(posedge clk) disable iff (!arst_n)
    v_fall |-> (v_len == VSYNC_CYCLES))
    else $error("vsync pulse is not three lines long");

  a_blank: assert property (@(posedge clk) disable iff (!arst_n)
    (video.hsync || video.vsync) |-> (video.rgb == 4'd0))
    else $error("colour output during sync");

  a_player_box: assert property (@(posedge clk) disable iff (!arst_n)
    ((settle >= 2'd2) && colour3) |-> in_box)
    else $error("player colour outside the player box");

  a_player_seen: assert property (@(posedge clk) disable iff (!arst_n)
    (frame_start && (settle >= 2'd2)) |-> c3_seen)
    else $error("player colour missing for a whole frame");

endmodule

`default_nettype wire

// File: bench/racing_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module racing_game_tb;

  localparam int FRAME_CYCLES   = int'(racing_pkg::H_TOTAL) * int'(racing_pkg::V_TOTAL);
  localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 2000;

  logic                  clk;
  logic                  arst_n;
  logic                  hpaddle;
  logic                  vpaddle;
  racing_pkg::bus_addr_t address;
  racing_pkg::byte_t     wdata;
  logic                  write;
  racing_pkg::byte_t     rdata;
  racing_pkg::video_t    video;
  racing_pkg::coord_t    model_hpos;
  racing_pkg::coord_t    model_vpos;
  racing_pkg::beam_t     model_beam;
  racing_pkg::byte_t     ram_model [64];
  int                    errors = 0;
  int                    checks = 0;
  int                    cycles = 0;

  racing_game_top u_racing_game_top (
    .clk(clk), .arst_n(arst_n), .hpaddle(hpaddle), .vpaddle(vpaddle), .address(address),
    .wdata(wdata), .write(write), .rdata(rdata), .video(video)
  );

  bind racing_game_top racing_game_properties u_properties (
    .clk(clk), .arst_n(arst_n), .hpaddle(hpaddle), .vpaddle(vpaddle), .address(address),
    .wdata(wdata), .write(write), .rdata(rdata), .video(video),
    .model_beam(racing_game_tb.model_beam)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reference beam counted from the end of reset
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      model_hpos <= '0;
      model_vpos <= '0;
    end else if (model_hpos == racing_pkg::H_TOTAL - 9'd1) begin
      model_hpos <= '0;
      model_vpos <= (model_vpos == racing_pkg::V_TOTAL - 9'd1) ? '0 : model_vpos + 9'd1;
    end else begin
      model_hpos <= model_hpos + 9'd1;
    end
  end

  assign model_beam.hpos       = model_hpos;
  assign model_beam.vpos       = model_vpos;
  assign model_beam.display_on = (model_hpos < racing_pkg::H_DISPLAY) &&
                                 (model_vpos < racing_pkg::V_DISPLAY);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the test sequence never finished", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // syncs lag the beam by one clock, so look at the previous position
  function automatic racing_pkg::byte_t expected_flags(input racing_pkg::coord_t h,
                                                       input racing_pkg::coord_t v,
                                                       input logic hp, input logic vp);
    racing_pkg::coord_t ph;
    racing_pkg::coord_t pv;
    racing_pkg::byte_t  f;
    ph = (h == '0) ? racing_pkg::H_TOTAL - 9'd1 : h - 9'd1;
    pv = v;
    if (h == '0) begin
      pv = (v == '0) ? racing_pkg::V_TOTAL - 9'd1 : v - 9'd1;
    end
    f = '0;
    f[racing_pkg::FLAG_DISPLAY] = (h < racing_pkg::H_DISPLAY) && (v < racing_pkg::V_DISPLAY);
    f[racing_pkg::FLAG_HPADDLE] = hp;
    f[racing_pkg::FLAG_VPADDLE] = vp;
    f[racing_pkg::FLAG_HSYNC] = (ph >= racing_pkg::H_SYNC_START) && (ph <= racing_pkg::H_SYNC_END);
    f[racing_pkg::FLAG_VSYNC] = (pv >= racing_pkg::V_SYNC_START) && (pv <= racing_pkg::V_SYNC_END);
    return f;
  endfunction

  task automatic check_byte(input string name, input racing_pkg::byte_t got,
                            input racing_pkg::byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail time=%0t signal=%s expected=%h got=%h", $time, name, exp, got);
    end
  endtask

  task automatic bus_write(input racing_pkg::bus_addr_t a, input racing_pkg::byte_t d);
    @(posedge clk);
    address <= a;
    wdata   <= d;
    write   <= 1'b1;
    @(posedge clk);
    write   <= 1'b0;
  endtask

  task automatic set_slot(input racing_pkg::ram_index_t s, input racing_pkg::byte_t d);
    bus_write({2'b00, s}, d);
  endtask

  // paddles change with every read
  task automatic bus_read(input racing_pkg::bus_addr_t a, output racing_pkg::byte_t d);
    logic [31:0] r;
    r = $urandom;
    @(posedge clk);
    address <= a;
    write   <= 1'b0;
    hpaddle <= r[0];
    vpaddle <= r[1];
    @(negedge clk);
    d = rdata;
  endtask

  task automatic check_flags(input racing_pkg::byte_t got);
    // collide bit depends on the scene and is checked on its own
    check_byte("flags", got & 8'hdf, expected_flags(model_hpos, model_vpos, hpaddle, vpaddle));
  endtask

  task automatic wait_for_pixel(input racing_pkg::coord_t h);
    do @(negedge clk); while (model_hpos != h);
  endtask

  task automatic wait_for_line(input racing_pkg::coord_t v);
    do @(negedge clk); while (model_vpos != v);
  endtask

  initial begin
    logic [31:0]           r;
    racing_pkg::bus_addr_t a;
    racing_pkg::byte_t     got;
    void'($urandom(32'h5298d36d));
    arst_n  = 1'b0;
    hpaddle = 1'b0;
    vpaddle = 1'b0;
    address = '0;
    wdata   = '0;
    write   = 1'b0;
    for (int i = 0; i < 64; i++) begin
      ram_model[i[5:0]] = '0;
    end
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    repeat (32) begin
      r = $urandom;
      bus_write({2'b00, r[5:0]}, r[15:8]);
      ram_model[r[5:0]] = r[15:8];
      @(negedge clk);
      check_byte("rdata", rdata, r[15:8]);
    end
    // writes above the RAM must not alias into it
    repeat (8) begin
      r = $urandom;
      a = (r[7:0] < racing_pkg::RAM_TOP) ? r[7:0] + racing_pkg::RAM_TOP : r[7:0];
      bus_write(a, r[15:8]);
    end
    for (int i = 0; i < 64; i++) begin
      bus_read({2'b00, i[5:0]}, got);
      check_byte("rdata", got, ram_model[i[5:0]]);
    end
    bus_read(8'h80, got);
    check_byte("rdata", got, 8'h00);

    // player in the clear lane and enemy far below
    set_slot(racing_pkg::SLOT_TRACK_POS, 8'd0);
    set_slot(racing_pkg::SLOT_PLAYER_X, 8'd100);
    set_slot(racing_pkg::SLOT_PLAYER_Y, 8'd80);
    set_slot(racing_pkg::SLOT_ENEMY_X, 8'd100);
    set_slot(racing_pkg::SLOT_ENEMY_Y, 8'd200);

    bus_read(racing_pkg::IN_HPOS, got);
    check_byte("hpos", got, model_hpos[7:0]);
    bus_read(racing_pkg::IN_VPOS, got);
    check_byte("vpos", got, model_vpos[7:0]);
    repeat (6) begin
      bus_read(racing_pkg::IN_FLAGS, got);
      check_flags(got);
    end
    wait_for_pixel(racing_pkg::H_SYNC_START + 9'd4);
    bus_read(racing_pkg::IN_FLAGS, got);
    check_flags(got);
    wait_for_line(racing_pkg::V_SYNC_START + 9'd1);
    bus_read(racing_pkg::IN_FLAGS, got);
    check_flags(got);

    // enemy shifted four pixels right onto the player
    set_slot(racing_pkg::SLOT_ENEMY_X, 8'd104);
    set_slot(racing_pkg::SLOT_ENEMY_Y, 8'd80);
    wait_for_line('0);
    wait_for_line(racing_pkg::V_DISPLAY);
    bus_read(racing_pkg::IN_FLAGS, got);
    check_byte("collide", {7'd0, got[racing_pkg::FLAG_COLLIDE]}, 8'd1);
    set_slot(racing_pkg::SLOT_ENEMY_X, 8'd100);
    set_slot(racing_pkg::SLOT_ENEMY_Y, 8'd200);
    wait_for_line('0);
    wait_for_line(racing_pkg::V_DISPLAY);
    bus_read(racing_pkg::IN_FLAGS, got);
    check_byte("collide", {7'd0, got[racing_pkg::FLAG_COLLIDE]}, 8'd0);
    // one more frame boundary so a clean frame is judged
    wait_for_line('0);
    wait_for_line(9'd1);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hdl/racing_pkg.sv
hdl/video_timing.sv
hdl/game_memory.sv
hdl/sprite_renderer.sv
hdl/playfield.sv
hdl/racing_game_top.sv
bench/racing_game_properties.sv
bench/racing_game_tb.sv

// File: run.sh
#!/bin/sh
# build and run the racing game regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module racing_game_tb \
  -f tb.f -o racing_game_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/racing_game_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
